//--- hdl/forward_unit.sv
`timescale 1ns/10ps

`include "hazard_params.svh"

module forward_unit import hazard_pkg::*; (
    input  ex_info_t  ex,
    input  mem_info_t mem,
    input  wb_info_t  wb,
    output fwd_sel_t  fwd
);

    // operand enables per integer path
    logic rd1_en;
    logic rd2_en;

    // integer select for one source register
    // mem beats wb, x0 never forwarded
    function automatic fwd_int_t int_sel(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic                   en,
        input mem_info_t              m,
        input wb_info_t               w
    );
        fwd_int_t sel;
        sel = fwd_int_none;
        if (en && m.reg_write && (rs == m.rd) && (rs != '0)) begin
            case (m.result_src)
                src_alu:        sel = fwd_int_alu;
                src_pc_plus4:   sel = fwd_int_pc_plus4;
                src_imm:        sel = fwd_int_imm;
                src_fpu_rd1:    sel = fwd_int_fpu_rd1;
                src_fpu_result: sel = fwd_int_fpu_result;
                // load, input and fmv_x not ready in mem yet
                default:        sel = fwd_int_alu;
            endcase
        end else if (en && w.reg_write && (rs == w.rd) && (rs != '0)) begin
            sel = fwd_int_wb;
        end
        return sel;
    endfunction

    // fpu select for one source register
    // no x0 special case in the fpu file
    function automatic fwd_fpu_t fpu_sel(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic                   en,
        input mem_info_t              m,
        input wb_info_t               w
    );
        fwd_fpu_t sel;
        sel = fwd_fpu_none;
        if (en && m.fpu_reg_write && (rs == m.rd)) begin
            case (m.result_src)
                src_fpu_result: sel = fwd_fpu_mem_result;
                // fmv.w.x ahead, integer rd1 carried in mem
                src_fmv_x:      sel = fwd_fpu_mem_fmv;
                default:        sel = fwd_fpu_none;
            endcase
        end else if (en && w.fpu_reg_write && (rs == w.rd)) begin
            sel = fwd_fpu_wb;
        end
        return sel;
    endfunction

    // fsw still takes its base address from integer rs1
    assign rd1_en = ~ex.s_fpu | ex.mem_write;
    // rs2 of an fpu instruction is always an fpu register
    assign rd2_en = ~ex.s_fpu;

    assign fwd.rd1 = int_sel(ex.rs1, rd1_en, mem, wb);
    assign fwd.rd2 = int_sel(ex.rs2, rd2_en, mem, wb);

    // fpu paths only matter for fpu instructions
    assign fwd.fpu_rd1 = fpu_sel(ex.rs1, ex.s_fpu, mem, wb);
    assign fwd.fpu_rd2 = fpu_sel(ex.rs2, ex.s_fpu, mem, wb);
    assign fwd.fpu_rd3 = fpu_sel(ex.rs3, ex.s_fpu, mem, wb);

endmodule

//--- hdl/fpu_issue_ctrl.sv
`timescale 1ns/10ps

module fpu_issue_ctrl (
    input  logic clk,
    input  logic rst,
    // fpu instruction sitting in execute
    input  logic dispatch,
    // result level from the fpu pipe
    input  logic valid,
    // memory back-pressure
    input  logic hold,
    output logic en_pulse,
    output logic fpu_stall
);

    // enable request and its last-cycle copy
    logic en_req;
    logic en_req_q;
    // pulse sent, result not seen yet
    logic waiting;

    // no start while memory is stalled
    // valid high means the result is already here
    assign en_req = dispatch & ~valid & ~hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            en_req_q <= 1'b0;
        end else begin
            en_req_q <= en_req;
        end
    end

    // rising edge of the request only
    // dispatch stays high while execute is frozen
    assign en_pulse = en_req & ~en_req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
        end else if (en_pulse) begin
            waiting <= 1'b1;
        end else if (valid) begin
            waiting <= 1'b0;
        end
    end

    // stall from the pulse cycle through the last cycle without valid
    assign fpu_stall = en_pulse | (waiting & ~valid);

endmodule

//--- hdl/hazard_params.svh
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// register index width
// 32 integer and 32 fpu registers share one index space
`define REG_ADDR_W 5

// width of the result source code carried down the pipe
// one code per writeback mux input
`define RESULT_SRC_W 3

`endif

//--- hdl/hazard_pkg.sv
package hazard_pkg;

    `include "hazard_params.svh"

    // writeback mux select as reported by each stage
    typedef enum logic [`RESULT_SRC_W-1:0] {
        src_alu        = 3'd0,
        src_load       = 3'd1,
        src_pc_plus4   = 3'd2,
        // fmv.w.x, integer value into the fpu register file
        src_fmv_x      = 3'd3,
        src_imm        = 3'd4,
        src_fpu_rd1    = 3'd5,
        src_fpu_result = 3'd6,
        src_input      = 3'd7
    } result_src_t;

    // integer operand mux in execute
    // mem codes reuse the result source encoding
    typedef enum logic [2:0] {
        fwd_int_alu        = 3'd0,
        fwd_int_wb         = 3'd1,
        fwd_int_pc_plus4   = 3'd2,
        fwd_int_imm        = 3'd4,
        fwd_int_fpu_rd1    = 3'd5,
        fwd_int_fpu_result = 3'd6,
        fwd_int_none       = 3'd7
    } fwd_int_t;

    // fpu operand mux in execute
    typedef enum logic [1:0] {
        fwd_fpu_none       = 2'd0,
        fwd_fpu_wb         = 2'd1,
        fwd_fpu_mem_result = 2'd2,
        fwd_fpu_mem_fmv    = 2'd3
    } fwd_fpu_t;

    // decode stage sources
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs3;
        logic                   s_fpu;
        logic                   mem_write;
        // fused multiply-add reads rs3
        logic                   r4;
    } id_info_t;

    // execute stage
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs3;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   pc_src;
        result_src_t            result_src;
        logic                   mem_write;
        logic                   s_fpu;
        logic                   reg_write;
        logic                   fpu_reg_write;
        logic                   fast_dispatch;
        logic                   slow_dispatch;
    } ex_info_t;

    // memory stage
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write;
        result_src_t            result_src;
        logic                   mem_write;
        logic                   mem_read;
        logic                   fpu_reg_write;
        logic                   in_issued;
    } mem_info_t;

    // writeback stage
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write;
        logic                   fpu_reg_write;
    } wb_info_t;

    typedef struct packed {
        fwd_int_t rd1;
        fwd_int_t rd2;
        fwd_fpu_t fpu_rd1;
        fwd_fpu_t fpu_rd2;
        fwd_fpu_t fpu_rd3;
    } fwd_sel_t;

    typedef struct packed {
        logic f;
        logic d;
        logic e;
        logic m;
        logic w;
    } stall_t;

    typedef struct packed {
        logic d;
        logic e;
        logic m;
    } flush_t;

endpackage

//--- hdl/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit import hazard_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // stage information from the pipeline
    input  id_info_t  id,
    input  ex_info_t  ex,
    input  mem_info_t mem,
    input  wb_info_t  wb,
    // data cache
    input  logic      cache_data_valid,
    // i/o module
    input  logic      in_data_valid,
    // fpu result levels
    input  logic      fast_fpu_valid,
    input  logic      slow_fpu_valid,
    // execute operand muxes
    output fwd_sel_t  fwd,
    output stall_t    stall,
    output flush_t    flush,
    output logic      lw_stall,
    output logic      cache_stall,
    output logic      in_stall,
    // one-cycle start strobes to the fpu
    output logic      fast_fpu_en,
    output logic      slow_fpu_en
);

    logic fast_stall;
    logic slow_stall;
    // memory back-pressure blocks a new fpu start
    logic fpu_hold;

    assign fpu_hold = cache_stall | in_stall;

    forward_unit i_forward_unit (
        .ex  (ex),
        .mem (mem),
        .wb  (wb),
        .fwd (fwd)
    );

    load_use_detect i_load_use_detect (
        .id       (id),
        .ex       (ex),
        .lw_stall (lw_stall)
    );

    // add, mul and friends, few cycles
    fpu_issue_ctrl i_fast_fpu_ctrl (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (ex.fast_dispatch),
        .valid     (fast_fpu_valid),
        .hold      (fpu_hold),
        .en_pulse  (fast_fpu_en),
        .fpu_stall (fast_stall)
    );

    // divide and square root
    fpu_issue_ctrl i_slow_fpu_ctrl (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (ex.slow_dispatch),
        .valid     (slow_fpu_valid),
        .hold      (fpu_hold),
        .en_pulse  (slow_fpu_en),
        .fpu_stall (slow_stall)
    );

    stall_flush_ctrl i_stall_flush_ctrl (
        .mem              (mem),
        .cache_data_valid (cache_data_valid),
        .in_data_valid    (in_data_valid),
        .lw_stall         (lw_stall),
        .pc_src           (ex.pc_src),
        .fast_stall       (fast_stall),
        .slow_stall       (slow_stall),
        .cache_stall      (cache_stall),
        .in_stall         (in_stall),
        .stall            (stall),
        .flush            (flush)
    );

endmodule

//--- hdl/load_use_detect.sv
`timescale 1ns/10ps

module load_use_detect import hazard_pkg::*; (
    input  id_info_t id,
    input  ex_info_t ex,
    output logic     lw_stall
);

    // result of execute not available until after mem
    logic ex_late;
    // some decode source reads the execute destination
    logic src_match;
    // decode reads from the same register file execute writes
    logic kind_match;
    // decode needs integer operands only
    logic id_int_src;

    // lw and input data both arrive one stage late
    assign ex_late = (ex.result_src == src_load) | (ex.result_src == src_input);

    // rs3 only read by r4-type fused ops
    assign src_match = (id.rs1 == ex.rd) |
                       (id.rs2 == ex.rd) |
                       (id.r4 & (id.rs3 == ex.rd));

    // fsw counts as integer here, base address from the integer file
    assign id_int_src = ~id.s_fpu | id.mem_write;

    assign kind_match = (id_int_src & ex.reg_write) |
                        (~id_int_src & ex.fpu_reg_write);

    assign lw_stall = ex_late & src_match & kind_match;

endmodule

//--- hdl/stall_flush_ctrl.sv
`timescale 1ns/10ps

module stall_flush_ctrl import hazard_pkg::*; (
    input  mem_info_t mem,
    input  logic      cache_data_valid,
    input  logic      in_data_valid,
    input  logic      lw_stall,
    // taken branch or jump in execute
    input  logic      pc_src,
    input  logic      fast_stall,
    input  logic      slow_stall,
    output logic      cache_stall,
    output logic      in_stall,
    output stall_t    stall,
    output flush_t    flush
);

    // freezes the whole pipe
    logic mem_stall;
    // either fpu pipe busy
    logic fpu_stall;

    // load or store waiting on the data cache
    assign cache_stall = (mem.mem_read | mem.mem_write) & ~cache_data_valid;
    // input instruction waiting on the i/o module
    assign in_stall = mem.in_issued & ~in_data_valid;

    assign mem_stall = cache_stall | in_stall;
    assign fpu_stall = fast_stall | slow_stall;

    // fetch address held by stall.f in every case
    assign stall.f = lw_stall | mem_stall | fpu_stall;
    assign stall.d = lw_stall | mem_stall | fpu_stall;
    // load-use lets execute move on, bubble goes in behind it
    assign stall.e = mem_stall | fpu_stall;
    assign stall.m = mem_stall;
    assign stall.w = mem_stall;

    assign flush.d = pc_src;
    // keep the load or input in execute while memory is stalled
    assign flush.e = (lw_stall | pc_src) & ~mem_stall;
    // fpu op must not reach mem until its result is valid
    assign flush.m = fpu_stall;

endmodule

//--- src.f
+incdir+hdl
hdl/hazard_pkg.sv
hdl/forward_unit.sv
hdl/load_use_detect.sv
hdl/fpu_issue_ctrl.sv
hdl/stall_flush_ctrl.sv
hdl/hazard_unit.sv
test/hazard_unit_chk.sv
test/hazard_unit_tb.sv

//--- test/hazard_unit_chk.sv
`timescale 1ns/10ps

module hazard_unit_chk import hazard_pkg::*; (
    input logic      clk,
    input logic      rst,
    input id_info_t  id,
    input ex_info_t  ex,
    input mem_info_t mem,
    input wb_info_t  wb,
    input logic      fast_fpu_valid,
    input logic      slow_fpu_valid,
    input fwd_sel_t  fwd,
    input stall_t    stall,
    input flush_t    flush,
    input logic      lw_stall,
    input logic      cache_stall,
    input logic      in_stall,
    input logic      fast_fpu_en,
    input logic      slow_fpu_en
);

    logic     failed = 1'b0;
    // integer path 1 also carries the fsw base address
    logic     rd1_live;
    // expected selects for a memory-stage match
    fwd_int_t mem_int;
    fwd_fpu_t mem_fpu;
    // start strobe seen, result not back yet
    logic     fast_busy;
    logic     slow_busy;

    assign rd1_live = ~ex.s_fpu | ex.mem_write;
    // load, input and fmv.w.x values not usable from mem
    assign mem_int = (mem.result_src inside {src_load, src_input, src_fmv_x}) ?
                     fwd_int_alu : fwd_int_t'(mem.result_src);
    assign mem_fpu = (mem.result_src == src_fpu_result) ? fwd_fpu_mem_result :
                     (mem.result_src == src_fmv_x) ? fwd_fpu_mem_fmv : fwd_fpu_none;

    always_ff @(posedge clk) begin
        if (rst) begin
            fast_busy <= 1'b0;
            slow_busy <= 1'b0;
        end else begin
            fast_busy <= fast_fpu_en | (fast_busy & ~fast_fpu_valid);
            slow_busy <= slow_fpu_en | (slow_busy & ~slow_fpu_valid);
        end
    end

    task automatic flag_failure(input string what);
        failed = 1'b1;
        $error("%s", what);
    endtask

    // mem match wins over wb, code follows result_src
    assert property (@(posedge clk) disable iff (rst)
        rd1_live && ex.rs1 != '0 && mem.reg_write && ex.rs1 == mem.rd |-> fwd.rd1 == mem_int)
        else flag_failure("rd1 memory forward select wrong");
    assert property (@(posedge clk) disable iff (rst)
        rd1_live && ex.rs1 != '0 && !(mem.reg_write && ex.rs1 == mem.rd) &&
        wb.reg_write && ex.rs1 == wb.rd |-> fwd.rd1 == fwd_int_wb)
        else flag_failure("rd1 writeback forward missing");
    assert property (@(posedge clk) disable iff (rst)
        !ex.s_fpu && ex.rs2 != '0 && !(mem.reg_write && ex.rs2 == mem.rd) &&
        wb.reg_write && ex.rs2 == wb.rd |-> fwd.rd2 == fwd_int_wb)
        else flag_failure("rd2 writeback forward missing");
    // x0 never, rs2 of an fpu op never
    assert property (@(posedge clk) disable iff (rst)
        (ex.rs1 != '0 || fwd.rd1 == fwd_int_none) &&
        ((ex.rs2 != '0 && !ex.s_fpu) || fwd.rd2 == fwd_int_none))
        else flag_failure("integer forward on x0 or on fpu rs2");
    assert property (@(posedge clk) disable iff (rst)
        ex.s_fpu && mem.fpu_reg_write && ex.rs1 == mem.rd |-> fwd.fpu_rd1 == mem_fpu)
        else flag_failure("fpu rd1 memory forward select wrong");
    // r4 third operand takes the same memory path
    assert property (@(posedge clk) disable iff (rst)
        ex.s_fpu && mem.fpu_reg_write && ex.rs3 == mem.rd |-> fwd.fpu_rd3 == mem_fpu)
        else flag_failure("fpu rd3 memory forward select wrong");
    assert property (@(posedge clk) disable iff (rst)
        ex.s_fpu && !(mem.fpu_reg_write && ex.rs2 == mem.rd) &&
        wb.fpu_reg_write && ex.rs2 == wb.rd |-> fwd.fpu_rd2 == fwd_fpu_wb)
        else flag_failure("fpu rd2 writeback forward missing");
    // integer-only writers never feed the fpu operands
    assert property (@(posedge clk) disable iff (rst)
        !mem.fpu_reg_write && !wb.fpu_reg_write |-> fwd.fpu_rd1 == fwd_fpu_none &&
        fwd.fpu_rd2 == fwd_fpu_none && fwd.fpu_rd3 == fwd_fpu_none)
        else flag_failure("fpu forward without an fpu write");
    assert property (@(posedge clk) disable iff (rst)
        ex.reg_write && ex.result_src inside {src_load, src_input} &&
        !id.s_fpu && id.rs1 == ex.rd |-> lw_stall)
        else flag_failure("load-use hazard not detected");
    // bubble behind the load, execute itself moves on
    assert property (@(posedge clk) disable iff (rst)
        lw_stall && !cache_stall && !in_stall |->
        stall.f && stall.d && flush.e && (flush.m || !stall.e))
        else flag_failure("load-use stall or flush wrong");
    // taken branch squashes the younger decode instruction
    assert property (@(posedge clk) disable iff (rst)
        ex.pc_src |-> flush.d)
        else flag_failure("taken branch did not flush decode");
    // memory back-pressure freezes everything
    assert property (@(posedge clk) disable iff (rst)
        cache_stall || in_stall |-> &stall && !flush.e && !fast_fpu_en && !slow_fpu_en)
        else flag_failure("memory stall did not freeze the pipe");
    assert property (@(posedge clk) disable iff (rst)
        !(fast_fpu_en && $past(fast_fpu_en)) && !(slow_fpu_en && $past(slow_fpu_en)))
        else flag_failure("fpu enable high on two cycles in a row");
    assert property (@(posedge clk) disable iff (rst)
        (fast_fpu_en || slow_fpu_en || (fast_busy && !fast_fpu_valid) ||
        (slow_busy && !slow_fpu_valid)) |-> stall.e && flush.m)
        else flag_failure("pipe not held while fpu result pending");

endmodule

bind hazard_unit hazard_unit_chk i_hazard_unit_chk (.*);

//--- test/hazard_unit_tb.sv
`timescale 1ns/10ps

module hazard_unit_tb import hazard_pkg::*; ();

    localparam int info_w = $bits(id_info_t) + $bits(ex_info_t) +
                            $bits(mem_info_t) + $bits(wb_info_t);

    logic        clk;
    logic        rst;
    id_info_t    id;
    ex_info_t    ex;
    mem_info_t   mem;
    wb_info_t    wb;
    logic        cache_data_valid;
    logic        in_data_valid;
    logic        fast_fpu_valid;
    logic        slow_fpu_valid;
    fwd_sel_t    fwd;
    stall_t      stall;
    flush_t      flush;
    logic        lw_stall;
    logic        cache_stall;
    logic        in_stall;
    logic        fast_fpu_en;
    logic        slow_fpu_en;
    // cycles until each fpu pipe answers
    int          fast_left;
    int          slow_left;
    logic [95:0] rnd;

    hazard_unit i_hazard_unit (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fpu model, valid for one cycle a fixed latency after the last start
    always @(posedge clk) begin
        if (rst) begin
            fast_left <= 0;
            slow_left <= 0;
        end else begin
            fast_left <= fast_fpu_en ? 3 : ((fast_left > 0) ? fast_left - 1 : 0);
            slow_left <= slow_fpu_en ? 12 : ((slow_left > 0) ? slow_left - 1 : 0);
        end
    end

    always @(negedge clk) begin
        fast_fpu_valid <= (fast_left == 1);
        slow_fpu_valid <= (slow_left == 1);
    end

    // checker raises its flag from the assertion action blocks
    always @(negedge clk) begin
        if (i_hazard_unit.i_hazard_unit_chk.failed) begin
            $display("Checks failed");
            $fatal(1, "an assertion in hazard_unit_chk failed");
        end
    end

    task automatic expect_value(input string test, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", test, exp, act);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_idle();
        id = '0;
        ex = '0;
        mem = '0;
        wb = '0;
        cache_data_valid = 1'b0;
        in_data_valid = 1'b0;
    endtask

    // one posedge for the checker, back on the falling edge
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    // hold dispatch until the pipe answers, count start strobes meanwhile
    task automatic issue_fpu(input string test, input logic slow);
        int pulses;
        int cycles;
        pulses = 0;
        cycles = 0;
        ex.fast_dispatch = ~slow;
        ex.slow_dispatch = slow;
        do begin
            @(posedge clk);
            pulses += int'(slow ? slow_fpu_en : fast_fpu_en);
            cycles++;
            if (cycles > 40) begin
                $display("Checks failed");
                $fatal(1, "%s: fpu result never became valid", test);
            end
        end while (!(slow ? slow_fpu_valid : fast_fpu_valid));
        @(negedge clk);
        ex.fast_dispatch = 1'b0;
        ex.slow_dispatch = 1'b0;
        expect_value(test, 1, pulses);
    endtask

    initial begin
        void'($urandom(50));
        drive_idle();
        fast_fpu_valid = 1'b0;
        slow_fpu_valid = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();
        expect_value("reset idle", 0, int'({stall, flush, fast_fpu_en, slow_fpu_en}));

        // every memory source code, wb matching too
        ex.rs1 = 5'd5;
        ex.rs2 = 5'd6;
        mem.rd = 5'd5;
        mem.reg_write = 1'b1;
        wb.rd = 5'd5;
        wb.reg_write = 1'b1;
        for (int c = 0; c < 8; c++) begin
            mem.result_src = result_src_t'(c);
            next_cycle();
        end
        // rd2 from writeback only
        wb.rd = 5'd6;
        next_cycle();
        ex.rs1 = '0;
        mem.rd = '0;
        wb.rd = '0;
        next_cycle();
        // fsw, base register forwarded, data register is fpu
        ex.s_fpu = 1'b1;
        ex.mem_write = 1'b1;
        ex.rs1 = 5'd5;
        ex.rs2 = 5'd5;
        mem.rd = 5'd5;
        next_cycle();

        // fpu operands
        drive_idle();
        ex.s_fpu = 1'b1;
        ex.rs1 = 5'd3;
        ex.rs2 = 5'd4;
        ex.rs3 = 5'd3;
        mem.rd = 5'd3;
        mem.fpu_reg_write = 1'b1;
        mem.result_src = src_fpu_result;
        wb.rd = 5'd4;
        wb.fpu_reg_write = 1'b1;
        next_cycle();
        mem.result_src = src_fmv_x;
        next_cycle();
        // integer-only writers
        mem.fpu_reg_write = 1'b0;
        mem.reg_write = 1'b1;
        wb.fpu_reg_write = 1'b0;
        wb.reg_write = 1'b1;
        next_cycle();

        // lw in execute, dependent add in decode
        drive_idle();
        ex.result_src = src_load;
        ex.rd = 5'd7;
        ex.reg_write = 1'b1;
        id.rs1 = 5'd7;
        next_cycle();
        // cache then input back-pressure over branch, load-use and fpu dispatch
        ex.pc_src = 1'b1;
        ex.fast_dispatch = 1'b1;
        mem.mem_read = 1'b1;
        repeat (3) next_cycle();
        mem.mem_read = 1'b0;
        mem.in_issued = 1'b1;
        repeat (3) next_cycle();
        drive_idle();
        issue_fpu("fast fpu issue", 1'b0);
        issue_fpu("slow fpu issue", 1'b1);

        for (int i = 0; i < 300; i++) begin
            rnd = {$urandom, $urandom, $urandom};
            {id, ex, mem, wb} = rnd[info_w-1:0];
            // bias toward register matches
            if (rnd[95]) mem.rd = ex.rs1;
            if (rnd[94]) wb.rd = ex.rs2;
            if (rnd[93]) id.rs1 = ex.rd;
            cache_data_valid = rnd[92] | rnd[91];
            in_data_valid = rnd[90] | rnd[89];
            next_cycle();
        end
        drive_idle();
        repeat (2) next_cycle();

        if (i_hazard_unit.i_hazard_unit_chk.failed) begin
            $display("Checks failed");
            $fatal(1, "an assertion in hazard_unit_chk failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
